// File: common/rob_pkg.sv
// Reorder buffer types
package rob_pkg;

	// row geometry
	localparam int NBANK = 4;
	localparam int NWB = 4;
	localparam int ROB_TAG_W = 4;

	typedef logic [6:0] preg_t;
	typedef logic [3:0] brtag_t;
	typedef logic [6:0] uop_t;
	typedef logic [31:0] pc_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [$clog2(NBANK)-1:0] bank_t;

	// one dispatched entry, 27 bits
	typedef struct packed {
		logic   val;
		logic   busy;
		uop_t   uop;
		preg_t  prd_old;
		preg_t  prd_new;
		brtag_t brtag;
	} dis_entry_t;

	// circular range tag..last, inclusive
	typedef struct packed {
		logic   en;
		brtag_t tag;
		brtag_t last;
	} kill_t;

	// execution unit completion
	typedef struct packed {
		logic     en;
		rob_tag_t row;
		bank_t    bank;
	} wb_t;

endpackage

// File: rob/rob_pc_ring.sv
// Row PC ring
`timescale 1ns/1ns

module rob_pc_ring import rob_pkg::*; #(
	parameter int ROWS = 8
) (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_we,
	input  logic            i_re,
	input  pc_t             i_pc,
	input  rob_tag_t        i_tag,
	output logic [ROWS-1:0] o_head,
	output logic [ROWS-1:0] o_tail,
	output logic            o_empty,
	output pc_t             o_pc,
	output pc_t             o_pc_next
);

	localparam int RW = $clog2(ROWS);

	logic [31:4]     pc_mem [ROWS];
	logic [ROWS-1:0] head_q;
	logic [ROWS-1:0] tail_q;
	logic            head_wrap_q;
	logic            tail_wrap_q;
	logic [RW-1:0]   row_sel;
	logic [RW-1:0]   row_next;

	function automatic logic [ROWS-1:0] rotl(input logic [ROWS-1:0] v);
		return {v[ROWS-2:0], v[ROWS-1]};
	endfunction

	// row PC bits only, the low nibble comes from the tag
	always_ff @(posedge i_clk) begin
		for (int i = 0; i < ROWS; i++) begin
			if (i_we && tail_q[i])
				pc_mem[i] <= i_pc[31:4];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			head_q      <= ROWS'(1);
			tail_q      <= ROWS'(1);
			head_wrap_q <= 1'b0;
			tail_wrap_q <= 1'b0;
		end else begin
			if (i_we) begin
				tail_q <= rotl(tail_q);
				if (tail_q[ROWS-1])
					tail_wrap_q <= ~tail_wrap_q;
			end
			if (i_re) begin
				head_q <= rotl(head_q);
				if (head_q[ROWS-1])
					head_wrap_q <= ~head_wrap_q;
			end
		end
	end

	// same slot, same lap
	assign o_empty = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);
	assign o_head  = head_q;
	assign o_tail  = tail_q;

	// tag is {row, entry}
	assign row_sel   = RW'(i_tag[ROB_TAG_W-1:2]);
	assign row_next  = row_sel + RW'(1);
	assign o_pc      = {pc_mem[row_sel], i_tag[1:0], 2'b00};
	assign o_pc_next = {pc_mem[row_next], 4'b0000};

endmodule

// File: rob/rob_bank.sv
// Reorder buffer bank
`timescale 1ns/1ns

module rob_bank import rob_pkg::*; #(
	parameter int ROWS = 8
) (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_we,
	input  dis_entry_t      i_entry,
	input  logic [ROWS-1:0] i_head,
	input  logic [ROWS-1:0] i_tail,
	input  logic [ROWS-1:0] i_busy_clr,
	input  kill_t           i_kill,
	output dis_entry_t      o_head_entry
);

	localparam int EW = $bits(dis_entry_t);

	logic [ROWS-1:0] val_q;
	logic [ROWS-1:0] busy_q;
	uop_t            uop_mem [ROWS];
	preg_t           prd_old_mem [ROWS];
	preg_t           prd_new_mem [ROWS];
	brtag_t          brtag_mem [ROWS];
	logic [ROWS-1:0] killed;
	dis_entry_t      slot [ROWS];
	logic [EW-1:0]   head_or;

	// brtag inside tag..last, wrapping through 15 to 0
	function automatic logic in_kill_range(input kill_t k, input brtag_t b);
		if (k.tag <= k.last)
			return (b >= k.tag) && (b <= k.last);
		return (b >= k.tag) || (b <= k.last);
	endfunction

	always_comb begin
		for (int i = 0; i < ROWS; i++)
			killed[i] = i_kill.en && in_kill_range(i_kill, brtag_mem[i]);
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			val_q  <= '0;
			busy_q <= '0;
		end else begin
			for (int i = 0; i < ROWS; i++) begin
				if (i_we && i_tail[i]) begin
					val_q[i]  <= i_entry.val;
					busy_q[i] <= i_entry.busy;
				end else begin
					// kill and writeback may land together
					if (killed[i])
						val_q[i] <= 1'b0;
					if (i_busy_clr[i])
						busy_q[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int i = 0; i < ROWS; i++) begin
			if (i_we && i_tail[i]) begin
				uop_mem[i]     <= i_entry.uop;
				prd_old_mem[i] <= i_entry.prd_old;
				prd_new_mem[i] <= i_entry.prd_new;
				brtag_mem[i]   <= i_entry.brtag;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < ROWS; i++) begin
			slot[i].val     = val_q[i];
			slot[i].busy    = busy_q[i];
			slot[i].uop     = uop_mem[i];
			slot[i].prd_old = prd_old_mem[i];
			slot[i].prd_new = prd_new_mem[i];
			slot[i].brtag   = brtag_mem[i];
		end
	end

	// one-hot head select
	always_comb begin
		head_or = '0;
		for (int i = 0; i < ROWS; i++)
			head_or = head_or | ({EW{i_head[i]}} & slot[i]);
	end

	assign o_head_entry = head_or;

endmodule

// File: rob/rob.sv
// Reorder buffer core
`timescale 1ns/1ns

module rob import rob_pkg::*; #(
	parameter int ROWS = 8
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_dis_we,
	input  pc_t              i_dis_pc,
	input  dis_entry_t       i_dis_row [NBANK],
	input  wb_t              i_wb [NWB],
	input  kill_t            i_kill,
	input  rob_tag_t         i_pc_tag,
	output pc_t              o_pc,
	output pc_t              o_pc_next,
	output logic [NBANK-1:0] o_com_en,
	output preg_t            o_com_prd [NBANK],
	output logic             o_credit_ret
);

	localparam int RW = $clog2(ROWS);

	logic [ROWS-1:0]  head;
	logic [ROWS-1:0]  tail;
	logic             empty;
	logic             retire;
	logic [ROWS-1:0]  busy_clr [NBANK];
	dis_entry_t       head_entry [NBANK];
	logic [NBANK-1:0] blocked;
	preg_t            free_prd [NBANK];
	logic             credit_q;

	rob_pc_ring #(
		.ROWS(ROWS)
	) pc_ring_i (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_we     (i_dis_we),
		.i_re     (retire),
		.i_pc     (i_dis_pc),
		.i_tag    (i_pc_tag),
		.o_head   (head),
		.o_tail   (tail),
		.o_empty  (empty),
		.o_pc     (o_pc),
		.o_pc_next(o_pc_next)
	);

	// writeback ports to per-bank busy clear
	always_comb begin
		for (int b = 0; b < NBANK; b++) begin
			busy_clr[b] = '0;
			for (int w = 0; w < NWB; w++) begin
				if (i_wb[w].en && i_wb[w].bank == bank_t'(b))
					busy_clr[b][i_wb[w].row[RW-1:0]] = 1'b1;
			end
		end
	end

	for (genvar b = 0; b < NBANK; b++) begin : g_bank
		rob_bank #(
			.ROWS(ROWS)
		) bank_i (
			.i_clk       (i_clk),
			.i_rst       (i_rst),
			.i_we        (i_dis_we),
			.i_entry     (i_dis_row[b]),
			.i_head      (head),
			.i_tail      (tail),
			.i_busy_clr  (busy_clr[b]),
			.i_kill      (i_kill),
			.o_head_entry(head_entry[b])
		);

		// a killed entry never blocks
		assign blocked[b] = head_entry[b].val & head_entry[b].busy;

		// killed entry gives back its new mapping
		assign free_prd[b] = head_entry[b].val ? head_entry[b].prd_old
		                                       : head_entry[b].prd_new;

		// p0 is never freed
		assign o_com_en[b]  = retire & (free_prd[b] != '0);
		assign o_com_prd[b] = free_prd[b];
	end

	assign retire = ~empty & ~|blocked;

	// one credit per retired row, a cycle later
	always_ff @(posedge i_clk) begin
		if (i_rst)
			credit_q <= 1'b0;
		else
			credit_q <= retire;
	end

	assign o_credit_ret = credit_q;

endmodule

// File: source/dis_credit_ctrl.sv
// Dispatch credit control
`timescale 1ns/1ns

module dis_credit_ctrl import rob_pkg::*; #(
	parameter int ROWS = 8
) (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_dis_valid,
	input  logic     i_credit_ret,
	output logic     o_dis_ready,
	output logic     o_dis_we,
	output rob_tag_t o_dis_tag
);

	localparam int RW = $clog2(ROWS);
	localparam int CW = $clog2(ROWS + 1);

	logic [CW-1:0] credits_q;
	logic [RW-1:0] tail_q;

	assign o_dis_ready = (credits_q != '0);
	assign o_dis_we    = i_dis_valid & o_dis_ready;
	assign o_dis_tag   = rob_tag_t'(tail_q);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			credits_q <= CW'(ROWS);
			tail_q    <= '0;
		end else begin
			// take and return together cancel out
			case ({o_dis_we, i_credit_ret})
				2'b10:   credits_q <= credits_q - 1'b1;
				2'b01:   credits_q <= credits_q + 1'b1;
				default: credits_q <= credits_q;
			endcase
			// ROWS is a power of two, wraps by itself
			if (o_dis_we)
				tail_q <= tail_q + 1'b1;
		end
	end

endmodule

// File: source/rob_top.sv
// Reorder buffer top
`timescale 1ns/1ns

module rob_top import rob_pkg::*; #(
	parameter int ROWS = 8
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_dis_valid,
	output logic             o_dis_ready,
	output rob_tag_t         o_dis_tag,
	input  pc_t              i_dis_pc,
	input  dis_entry_t       i_dis_row [NBANK],
	input  wb_t              i_wb [NWB],
	input  kill_t            i_kill,
	input  rob_tag_t         i_pc_tag,
	output pc_t              o_pc,
	output pc_t              o_pc_next,
	output logic [NBANK-1:0] o_com_en,
	output preg_t            o_com_prd [NBANK]
);

	logic dis_we;
	logic credit_ret;

	dis_credit_ctrl #(
		.ROWS(ROWS)
	) credit_i (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_dis_valid (i_dis_valid),
		.i_credit_ret(credit_ret),
		.o_dis_ready (o_dis_ready),
		.o_dis_we    (dis_we),
		.o_dis_tag   (o_dis_tag)
	);

	rob #(
		.ROWS(ROWS)
	) rob_i (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_dis_we    (dis_we),
		.i_dis_pc    (i_dis_pc),
		.i_dis_row   (i_dis_row),
		.i_wb        (i_wb),
		.i_kill      (i_kill),
		.i_pc_tag    (i_pc_tag),
		.o_pc        (o_pc),
		.o_pc_next   (o_pc_next),
		.o_com_en    (o_com_en),
		.o_com_prd   (o_com_prd),
		.o_credit_ret(credit_ret)
	);

endmodule

// File: dv/rob_model.svh
// Reorder buffer reference model
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// one dispatched row as the model sees it
typedef struct packed {
	rob_tag_t                 slot;
	pc_t                      pc;
	dis_entry_t [NBANK-1:0]   e;
} model_row_t;

// rows in flight, oldest first
model_row_t rows_q [$];

// distance from the mispredicted tag, modulo 16
function automatic logic kill_hit(input kill_t k, input brtag_t b);
	brtag_t dist_b;
	brtag_t dist_last;
	dist_b = b - k.tag;
	dist_last = k.last - k.tag;
	return k.en && (dist_b <= dist_last);
endfunction

// surviving entry frees the old mapping, killed one the new
function automatic preg_t freed_prd(input dis_entry_t e);
	if (e.val)
		return e.prd_old;
	return e.prd_new;
endfunction

task automatic model_kill(input kill_t k);
	model_row_t r;
	for (int i = 0; i < rows_q.size(); i++) begin
		r = rows_q[i];
		for (int b = 0; b < NBANK; b++) begin
			if (kill_hit(k, r.e[b].brtag))
				r.e[b].val = 1'b0;
		end
		rows_q[i] = r;
	end
endtask

`endif

// File: dv/rob_tb.sv
// Reorder buffer testbench
`timescale 1ns/1ns

module rob_tb import rob_pkg::*;;

	localparam int ROWS = 8;
	localparam int NTESTS = 5;

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	logic       dis_valid;
	logic       dis_ready;
	rob_tag_t   dis_tag;
	pc_t        dis_pc;
	dis_entry_t dis_row [NBANK];
	wb_t        wb [NWB];
	kill_t      kill;
	rob_tag_t   pc_tag;
	pc_t        pc_out;
	pc_t        pc_next;
	logic [NBANK-1:0] com_en;
	preg_t      com_prd [NBANK];

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     tail_cnt = 0;
	wb_t    pending [$];
	pc_t    pc_slot [ROWS];

	`include "rob_model.svh"

	rob_top #(
		.ROWS(ROWS)
	) rob_top_i (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_dis_valid(dis_valid),
		.o_dis_ready(dis_ready),
		.o_dis_tag  (dis_tag),
		.i_dis_pc   (dis_pc),
		.i_dis_row  (dis_row),
		.i_wb       (wb),
		.i_kill     (kill),
		.i_pc_tag   (pc_tag),
		.o_pc       (pc_out),
		.o_pc_next  (pc_next),
		.o_com_en   (com_en),
		.o_com_prd  (com_prd)
	);

	always #10 clk = ~clk;

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// all_busy keeps the row in flight until written back
	function automatic model_row_t gen_row(input logic all_busy);
		model_row_t r;
		r.slot = '0;
		r.pc = pc_t'($random(seed));
		for (int b = 0; b < NBANK; b++) begin
			r.e[b].val = 1'b1;
			r.e[b].busy = all_busy ? 1'b1 : logic'(rand_below(2));
			r.e[b].uop = uop_t'(rand_below(128));
			r.e[b].prd_old = preg_t'(rand_below(128));
			r.e[b].prd_new = preg_t'(rand_below(128));
			r.e[b].brtag = brtag_t'(rand_below(16));
			// bank 0 always frees a register so every retire is visible
			if (b == 0) begin
				if (r.e[b].prd_old == '0)
					r.e[b].prd_old = 7'd1;
				if (r.e[b].prd_new == '0)
					r.e[b].prd_new = 7'd1;
			end else begin
				if (rand_below(4) == 0)
					r.e[b].prd_old = '0;
				if (rand_below(4) == 0)
					r.e[b].prd_new = '0;
			end
		end
		return r;
	endfunction

	// entry named by a writeback is no longer busy
	task automatic mark_done(input wb_t p);
		model_row_t r;
		if (p.en) begin
			for (int i = 0; i < rows_q.size(); i++) begin
				r = rows_q[i];
				if (r.slot == p.row) begin
					r.e[p.bank].busy = 1'b0;
					rows_q[i] = r;
				end
			end
		end
	endtask

	// one cycle of up to four writebacks in random order
	task automatic issue_wb_cycle();
		int n;
		int idx;
		n = 1 + rand_below(NWB);
		for (int w = 0; w < n; w++) begin
			if (pending.size() != 0) begin
				idx = rand_below(pending.size());
				wb[w] = pending[idx];
				pending.delete(idx);
			end
		end
		@(posedge clk);
		for (int w = 0; w < NWB; w++)
			mark_done(wb[w]);
		#2;
		for (int w = 0; w < NWB; w++)
			wb[w] = '0;
	endtask

	task automatic dispatch_row(input model_row_t r);
		int cyc;
		cyc = 0;
		while (!dis_ready && cyc < 100) begin
			issue_wb_cycle();
			cyc++;
		end
		if (!dis_ready) begin
			$display("dispatch was never accepted, ready stayed low at %0t ns", $time);
			errors++;
		end else begin
			check(dis_tag, tail_cnt % ROWS, "o_dis_tag");
			r.slot = rob_tag_t'(tail_cnt % ROWS);
			dis_pc = r.pc;
			for (int b = 0; b < NBANK; b++) begin
				dis_row[b] = r.e[b];
				if (r.e[b].busy)
					pending.push_back('{en: 1'b1, row: r.slot, bank: bank_t'(b)});
			end
			dis_valid = 1'b1;
			pc_slot[r.slot] = r.pc;
			rows_q.push_back(r);
			tail_cnt++;
			@(posedge clk);
			#2;
			dis_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int cyc;
		cyc = 0;
		while ((pending.size() != 0 || rows_q.size() != 0) && cyc < 300) begin
			issue_wb_cycle();
			cyc++;
		end
		if (rows_q.size() != 0) begin
			$display("%0d rows never retired by %0t ns", rows_q.size(), $time);
			errors++;
		end
		// let the credits come back
		repeat (3) @(posedge clk);
		#2;
	endtask

	task automatic apply_kill(input brtag_t tag, input brtag_t last);
		kill = '{en: 1'b1, tag: tag, last: last};
		@(posedge clk);
		model_kill(kill);
		#2;
		kill = '0;
	endtask

	function automatic logic pending_dead(input wb_t p);
		for (int i = 0; i < rows_q.size(); i++) begin
			if (rows_q[i].slot == p.row)
				return !rows_q[i].e[p.bank].val;
		end
		return 1'b1;
	endfunction

	task automatic hold_rejected(input int n);
		model_row_t r;
		r = gen_row(1'b1);
		for (int b = 0; b < NBANK; b++)
			dis_row[b] = r.e[b];
		dis_valid = 1'b1;
		for (int i = 0; i < n; i++) begin
			check(dis_ready, 0, "o_dis_ready while full");
			@(posedge clk);
			#2;
			check(dis_tag, tail_cnt % ROWS, "o_dis_tag while full");
		end
		dis_valid = 1'b0;
	endtask

	task automatic end_test(input int n, input string name, input int err0);
		$display("test %0d %s: %s", n, name, (errors == err0) ? "passed" : "failed");
	endtask

	// compare process checks one retired row per cycle
	always @(negedge clk) begin
		model_row_t r;
		preg_t exp;
		if (!rst && com_en != '0) begin
			if (rows_q.size() == 0) begin
				$display("a row retired with none in flight at %0t ns", $time);
				errors++;
			end else begin
				r = rows_q.pop_front();
				for (int b = 0; b < NBANK; b++) begin
					exp = freed_prd(r.e[b]);
					check(r.e[b].val & r.e[b].busy, 0,
					      $sformatf("busy of retired entry %0d", b));
					check(com_en[b], exp != '0, $sformatf("o_com_en[%0d]", b));
					if (exp != '0)
						check(com_prd[b], exp, $sformatf("o_com_prd[%0d]", b));
				end
			end
		end
	end

	initial begin
		#(NTESTS * 2000 + 16 * 20);
		$display("run timed out before all tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int err0;
		int h;
		int cyc;
		int nrow;
		int row;
		int ent;
		wb_t keep [$];
		seed = 32'h62d8_0838;
		dis_valid = 1'b0;
		dis_pc = '0;
		kill = '0;
		pc_tag = '0;
		for (int b = 0; b < NBANK; b++)
			dis_row[b] = '0;
		for (int w = 0; w < NWB; w++)
			wb[w] = '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		err0 = errors;
		check(com_en, 0, "o_com_en after reset");
		check(dis_ready, 1, "o_dis_ready after reset");
		check(dis_tag, 0, "o_dis_tag after reset");
		end_test(1, "reset", err0);

		err0 = errors;
		for (int i = 0; i < 12; i++) begin
			dispatch_row(gen_row(1'b0));
			if (pending.size() != 0)
				issue_wb_cycle();
		end
		drain();
		end_test(2, "in-order retire", err0);

		err0 = errors;
		for (int k = 0; k < 2; k++) begin
			for (int i = 0; i < ROWS - 2; i++)
				dispatch_row(gen_row(1'b0));
			// first range wraps through 15 to 0
			if (k == 0)
				apply_kill(4'd14, 4'd2);
			else
				apply_kill(4'd5, 4'd9);
			keep.delete();
			foreach (pending[i]) begin
				if (!pending_dead(pending[i]))
					keep.push_back(pending[i]);
			end
			pending = keep;
			drain();
		end
		end_test(3, "branch kill", err0);

		err0 = errors;
		h = tail_cnt % ROWS;
		for (int i = 0; i < ROWS; i++)
			dispatch_row(gen_row(1'b1));
		hold_rejected(4);
		keep.delete();
		foreach (pending[i]) begin
			if (pending[i].row != rob_tag_t'(h))
				keep.push_back(pending[i]);
		end
		pending = keep;
		for (int w = 0; w < NWB; w++)
			wb[w] = '{en: 1'b1, row: rob_tag_t'(h), bank: bank_t'(w)};
		@(posedge clk);
		for (int w = 0; w < NWB; w++)
			mark_done(wb[w]);
		#2;
		for (int w = 0; w < NWB; w++)
			wb[w] = '0;
		cyc = 0;
		while (!dis_ready && cyc < 10) begin
			@(posedge clk);
			#2;
			cyc++;
		end
		check(dis_ready, 1, "o_dis_ready after one retire");
		dispatch_row(gen_row(1'b1));
		hold_rejected(3);
		drain();
		end_test(4, "credit back-pressure", err0);

		err0 = errors;
		for (int i = 0; i < ROWS; i++)
			dispatch_row(gen_row(1'b1));
		nrow = (ROWS < 4) ? ROWS : 4;
		for (int i = 0; i < 20; i++) begin
			row = rand_below(nrow);
			ent = rand_below(4);
			pc_tag = rob_tag_t'({row[1:0], ent[1:0]});
			#1;
			check(pc_out, {pc_slot[row][31:4], ent[1:0], 2'b00}, "o_pc");
			check(pc_next, {pc_slot[(row + 1) % ROWS][31:4], 4'b0000}, "o_pc_next");
			@(posedge clk);
			#2;
		end
		drain();
		end_test(5, "PC lookup", err0);

		$display("%0d tests, %0d checks, %0d errors", NTESTS, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tb.f
+incdir+dv
common/rob_pkg.sv
rob/rob_pc_ring.sv
rob/rob_bank.sv
rob/rob.sv
source/dis_credit_ctrl.sv
source/rob_top.sv
dv/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := rob_tb
FLIST     := tb.f
OBJ       := obj_dir
BIN       := $(OBJ)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
